// ==== include/la_regmap.svh ====
// logic analyzer register map
// byte offsets on the word bus and bit positions in the ctl and status words

`ifndef LA_REGMAP_SVH
`define LA_REGMAP_SVH

// acquisition regset
`define la_reg_ctl         7'h00
`define la_reg_mode        7'h04
`define la_reg_trg         7'h08
`define la_reg_pre         7'h10
`define la_reg_pst         7'h14
`define la_reg_sts_pre     7'h18
`define la_reg_sts_pst     7'h1c
// timestamps, low word then high word
`define la_reg_cts_acq_lo  7'h20
`define la_reg_cts_acq_hi  7'h24
`define la_reg_cts_trg_lo  7'h28
`define la_reg_cts_trg_hi  7'h2c
`define la_reg_cts_stp_lo  7'h30
`define la_reg_cts_stp_hi  7'h34
// trigger detector and decimation
`define la_reg_cmp_msk     7'h40
`define la_reg_cmp_val     7'h44
`define la_reg_edg_pos     7'h48
`define la_reg_edg_neg     7'h4c
`define la_reg_dec         7'h50

// ctl write bits
`define la_ctl_rst  0
`define la_ctl_acq  1
`define la_ctl_stp  2
`define la_ctl_trg  3

`endif

// ==== verilog/la_pkg.sv ====
// logic analyzer package
// widths, the sample type and the configuration struct

package la_pkg;

  // sample width
  localparam int unsigned dw  = 8;
  // decimation counter width
  localparam int unsigned dcw = 17;
  // pre/post trigger counter width
  localparam int unsigned cw  = 17;
  // number of trigger sources
  localparam int unsigned tn  = 4;
  // timestamp width
  localparam int unsigned tw  = 64;
  // bus address width
  localparam int unsigned baw = 7;

  // one sample on the stream
  typedef logic [dw-1:0] dat_t;

  // everything the register block hands to the datapath
  typedef struct packed {
    logic            con;      // continuous, post limit ignored
    logic            aut;      // re-arm after a capture ends
    logic [tn-1:0]   trg;      // trigger source select
    logic [cw-1:0]   pre;      // pre-trigger samples
    logic [cw-1:0]   pst;      // post-trigger samples
    dat_t            cmp_msk;
    dat_t            cmp_val;
    dat_t            edg_pos;
    dat_t            edg_neg;
    logic [dcw-1:0]  dec;      // keep one of dec+1
  } la_cfg_t;

endpackage

// ==== verilog/str_if.sv ====
// sample stream interface
// valid/ready transfer with a last marker, src drives and drn receives

`timescale 1ns/1ns

interface str_if import la_pkg::*; ();

  // payload
  dat_t  dat;
  // handshake, transfer when both high
  logic  vld;
  logic  rdy;
  // final sample of a capture
  logic  lst;

  // producer side
  modport src (output dat, output vld, output lst, input rdy);

  // consumer side, also used as a passive monitor
  modport drn (input dat, input vld, input lst, output rdy);

endinterface

// ==== verilog/la_regs.sv ====
// logic analyzer register block
// word bus decode into the configuration struct, ctl strobes
// and a registered status/config readback

`timescale 1ns/1ns

`include "la_regmap.svh"

module la_regs import la_pkg::*; (
  input  logic            bus,
  input  logic            rst,
  // word bus
  input  logic            wen,
  input  logic            ren,
  input  logic [baw-1:0]  addr,
  input  logic [31:0]     wdata,
  output logic [31:0]     rdata,
  output logic            ack,
  // status from acquisition
  input  logic            sts_acq,
  input  logic            sts_trg,
  input  logic [cw-1:0]   sts_pre,
  input  logic [cw-1:0]   sts_pst,
  input  logic [tw-1:0]   cts_acq,
  input  logic [tw-1:0]   cts_trg,
  input  logic [tw-1:0]   cts_stp,
  // configuration and strobes
  output la_cfg_t         cfg,
  output logic            ctl_rst,
  output logic            ctl_acq,
  output logic            ctl_stp,
  output logic            trg_swo
);

  logic         ctl_wr;
  logic [31:0]  rd_word;

  // one cycle answer to any access
  always_ff @(posedge bus) begin
    if (rst) begin
      ack <= 1'b0;
    end else begin
      ack <= wen | ren;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst) begin
      cfg <= '0;
    end else if (wen) begin
      case (addr)
        `la_reg_mode: begin
          cfg.con <= wdata[0];
          cfg.aut <= wdata[1];
        end
        `la_reg_trg:     cfg.trg     <= wdata[tn-1:0];
        `la_reg_pre:     cfg.pre     <= wdata[cw-1:0];
        `la_reg_pst:     cfg.pst     <= wdata[cw-1:0];
        `la_reg_cmp_msk: cfg.cmp_msk <= wdata[dw-1:0];
        `la_reg_cmp_val: cfg.cmp_val <= wdata[dw-1:0];
        `la_reg_edg_pos: cfg.edg_pos <= wdata[dw-1:0];
        `la_reg_edg_neg: cfg.edg_neg <= wdata[dw-1:0];
        `la_reg_dec:     cfg.dec     <= wdata[dcw-1:0];
        default: ;
      endcase
    end
  end

  // ctl strobes, live in the write cycle itself
  assign ctl_wr  = wen & (addr == `la_reg_ctl);
  assign ctl_rst = ctl_wr & wdata[`la_ctl_rst];
  assign ctl_acq = ctl_wr & wdata[`la_ctl_acq];
  assign ctl_stp = ctl_wr & wdata[`la_ctl_stp];
  assign trg_swo = ctl_wr & wdata[`la_ctl_trg];

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (addr)
      // status: triggered, idle, acquiring
      `la_reg_ctl:        rd_word = {28'd0, sts_trg, ~sts_acq, sts_acq, 1'b0};
      `la_reg_mode:       rd_word = {30'd0, cfg.aut, cfg.con};
      `la_reg_trg:        rd_word = 32'(cfg.trg);
      `la_reg_pre:        rd_word = 32'(cfg.pre);
      `la_reg_pst:        rd_word = 32'(cfg.pst);
      `la_reg_sts_pre:    rd_word = 32'(sts_pre);
      `la_reg_sts_pst:    rd_word = 32'(sts_pst);
      `la_reg_cts_acq_lo: rd_word = cts_acq[31:0];
      `la_reg_cts_acq_hi: rd_word = cts_acq[63:32];
      `la_reg_cts_trg_lo: rd_word = cts_trg[31:0];
      `la_reg_cts_trg_hi: rd_word = cts_trg[63:32];
      `la_reg_cts_stp_lo: rd_word = cts_stp[31:0];
      `la_reg_cts_stp_hi: rd_word = cts_stp[63:32];
      `la_reg_cmp_msk:    rd_word = 32'(cfg.cmp_msk);
      `la_reg_cmp_val:    rd_word = 32'(cfg.cmp_val);
      `la_reg_edg_pos:    rd_word = 32'(cfg.edg_pos);
      `la_reg_edg_neg:    rd_word = 32'(cfg.edg_neg);
      `la_reg_dec:        rd_word = 32'(cfg.dec);
      default:            rd_word = '0;
    endcase
  end

  // sampled with the request, valid alongside ack
  always_ff @(posedge bus) begin
    if (ren) begin
      rdata <= rd_word;
    end
  end

  // a request is either a write or a read
  ap_req_one: assert property (@(posedge bus) disable iff (rst)
    !(wen && ren))
    else $error("write and read requested in the same cycle");

endmodule

// ==== verilog/str_dec.sv ====
// stream decimator
// forwards one of every dec+1 accepted transfers through a register stage

`timescale 1ns/1ns

module str_dec import la_pkg::*; (
  input  logic            bus,
  input  logic            rst,
  input  logic            ctl_rst,
  input  logic [dcw-1:0]  dec,
  str_if.drn              sti,
  str_if.src              sto
);

  logic [dcw-1:0]  cnt;
  logic            keep;
  logic            xfr;
  dat_t            dat_q;
  logic            vld_q;
  logic            lst_q;

  // count zero marks the sample to keep
  assign keep = (cnt == '0);
  // dropped samples never wait, kept ones need room
  assign sti.rdy = ~keep | ~vld_q | sto.rdy;
  assign xfr = sti.vld & sti.rdy;

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      cnt   <= '0;
      vld_q <= 1'b0;
    end else begin
      if (xfr) begin
        // wrap after dec, also when dec shrank under the count
        cnt <= (cnt >= dec) ? '0 : cnt + dcw'(1);
      end
      if (xfr && keep) begin
        vld_q <= 1'b1;
      end else if (sto.rdy) begin
        vld_q <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge bus) begin
    if (xfr && keep) begin
      dat_q <= sti.dat;
      lst_q <= sti.lst;
    end
  end

  assign sto.dat = dat_q;
  assign sto.vld = vld_q;
  assign sto.lst = lst_q;

  // held output under back-pressure
  ap_hold: assert property (@(posedge bus) disable iff (rst)
    sto.vld && !sto.rdy |=> $stable(sto.dat))
    else $error("decimator output changed while stalled");

endmodule

// ==== verilog/la_trigger.sv ====
// trigger detector
// masked pattern compare together with a rising or falling edge,
// watching the stream without taking part in the handshake

`timescale 1ns/1ns

module la_trigger import la_pkg::*; (
  input  logic  bus,
  input  logic  rst,
  input  logic  ctl_rst,
  // detector setup
  input  dat_t  cmp_msk,
  input  dat_t  cmp_val,
  input  dat_t  edg_pos,
  input  dat_t  edg_neg,
  // monitored stream
  str_if.drn    str,
  output logic  trg_out
);

  dat_t  prv;
  logic  xfr;
  logic  cmp_hit;
  logic  edg_hit;

  // a sample counts only once it is actually transferred
  assign xfr = str.vld & str.rdy;

  // masked bits equal
  assign cmp_hit = ((str.dat & cmp_msk) == (cmp_val & cmp_msk));

  // selected bit rose or fell against the last sample
  assign edg_hit = |((str.dat & ~prv & edg_pos) | (~str.dat & prv & edg_neg));

  always_ff @(posedge bus) begin
    if (rst) begin
      prv     <= '0;
      trg_out <= 1'b0;
    end else begin
      // one cycle pulse after the qualifying transfer
      trg_out <= xfr & cmp_hit & edg_hit;
      if (ctl_rst) begin
        prv <= '0;
      end else if (xfr) begin
        prv <= str.dat;
      end
    end
  end

endmodule

// ==== verilog/la_acq.sv ====
// acquisition sequencer
// pre-trigger count, trigger wait, post-trigger count, timestamps
// and a registered output stage marking the last sample

`timescale 1ns/1ns

module la_acq import la_pkg::*; (
  input  logic            bus,
  input  logic            rst,
  input  logic [tw-1:0]   cts,
  input  logic            ctl_rst,
  input  logic            ctl_acq,
  input  logic            ctl_stp,
  input  logic [tn-1:0]   trg_src,
  input  la_cfg_t         cfg,
  str_if.drn              sti,
  str_if.src              sto,
  output logic            sts_acq,
  output logic            sts_trg,
  output logic [cw-1:0]   sts_pre,
  output logic [cw-1:0]   sts_pst,
  output logic [tw-1:0]   cts_acq,
  output logic [tw-1:0]   cts_trg,
  output logic [tw-1:0]   cts_stp
);

  logic           xfr;
  logic           take;
  logic           run;
  logic           trg_hld;
  logic           trg_fire;
  logic           pre_done;
  logic [cw:0]    pst_nxt;
  logic           pst_end;
  logic           end_xfr;
  logic           stp_evt;
  dat_t           dat_q;
  logic           vld_q;
  logic           lst_q;

  ////////////////////////////////////////////////////////////////////////////
  // sequencing terms
  ////////////////////////////////////////////////////////////////////////////

  // idle input always ready, samples dropped
  assign sti.rdy = ~sts_acq | ~vld_q | sto.rdy;
  assign xfr  = sti.vld & sti.rdy;
  assign take = xfr & sts_acq;

  // no strobe pending this cycle
  assign run = sts_acq & ~ctl_rst & ~ctl_acq & ~ctl_stp;

  assign pre_done = (sts_pre >= cfg.pre);
  // trigger_hld is the per-capture flag, sts_trg the sticky status
  assign trg_fire = run & ~trg_hld & pre_done & |(trg_src & cfg.trg);

  // pst of zero or one ends on the first post sample
  assign pst_nxt = {1'b0, sts_pst} + (cw+1)'(1);
  assign pst_end = (pst_nxt >= {1'b0, cfg.pst});
  assign end_xfr = run & take & trg_hld & ~cfg.con & pst_end;

  assign stp_evt = end_xfr | (ctl_stp & ~ctl_acq & ~ctl_rst);

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      sts_acq <= 1'b0;
      sts_trg <= 1'b0;
      trg_hld <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
    end else if (ctl_acq) begin
      // fresh start, status cleared too
      sts_acq <= 1'b1;
      sts_trg <= 1'b0;
      trg_hld <= 1'b0;
      sts_pre <= '0;
      sts_pst <= '0;
    end else if (ctl_stp) begin
      sts_acq <= 1'b0;
    end else if (sts_acq) begin
      if (trg_fire) begin
        sts_trg <= 1'b1;
        trg_hld <= 1'b1;
      end
      if (take) begin
        if (!pre_done) sts_pre <= sts_pre + cw'(1);
        if (trg_hld) sts_pst <= sts_pst + cw'(1);
      end
      // capture complete, aut keeps running with counters cleared
      if (end_xfr) begin
        sts_acq <= cfg.aut;
        trg_hld <= 1'b0;
        if (cfg.aut) begin
          sts_pre <= '0;
          sts_pst <= '0;
        end
      end
    end
  end

  // timestamps
  always_ff @(posedge bus) begin
    if (ctl_acq) cts_acq <= cts;
    if (trg_fire) cts_trg <= cts;
    if (stp_evt) cts_stp <= cts;
  end

  ////////////////////////////////////////////////////////////////////////////
  // output stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus) begin
    if (rst || ctl_rst) begin
      vld_q <= 1'b0;
      lst_q <= 1'b0;
    end else if (take) begin
      vld_q <= 1'b1;
      lst_q <= end_xfr;
    end else if (sto.rdy) begin
      vld_q <= 1'b0;
      lst_q <= 1'b0;
    end
  end

  always_ff @(posedge bus) begin
    if (take) dat_q <= sti.dat;
  end

  assign sto.dat = dat_q;
  assign sto.vld = vld_q;
  assign sto.lst = lst_q;

  // stalled output holds its sample and marker
  ap_out_hold: assert property (@(posedge bus) disable iff (rst || ctl_rst)
    sto.vld && !sto.rdy |=> sto.vld && $stable(sto.dat) && $stable(sto.lst))
    else $error("output stage changed while stalled");

endmodule

// ==== verilog/la_top.sv ====
// logic analyzer top level
// registers, decimator, trigger detector and acquisition
// joined over internal streams, plain stream and bus ports outside

`timescale 1ns/1ns

module la_top import la_pkg::*; (
  input  logic            bus,
  input  logic            rst,
  // word bus
  input  logic            wen,
  input  logic            ren,
  input  logic [baw-1:0]  addr,
  input  logic [31:0]     wdata,
  output logic [31:0]     rdata,
  output logic            ack,
  // timestamp and external triggers
  input  logic [tw-1:0]   cts,
  input  logic [1:0]      trg_ext,
  // input stream
  input  dat_t            sti_dat,
  input  logic            sti_vld,
  output logic            sti_rdy,
  // output stream
  output dat_t            sto_dat,
  output logic            sto_vld,
  output logic            sto_lst,
  input  logic            sto_rdy,
  // trigger outputs
  output logic            trg_out,
  output logic            trg_swo
);

  la_cfg_t          cfg;
  logic             ctl_rst;
  logic             ctl_acq;
  logic             ctl_stp;
  logic             sts_acq;
  logic             sts_trg;
  logic [cw-1:0]    sts_pre;
  logic [cw-1:0]    sts_pst;
  logic [tw-1:0]    cts_acq;
  logic [tw-1:0]    cts_trg;
  logic [tw-1:0]    cts_stp;
  logic [tn-1:0]    trg_src;

  str_if sti ();
  str_if std ();
  str_if sto ();

  // wrap the plain stream ports, input has no last marker
  assign sti.dat = sti_dat;
  assign sti.vld = sti_vld;
  assign sti.lst = 1'b0;
  assign sti_rdy = sti.rdy;
  assign sto_dat = sto.dat;
  assign sto_vld = sto.vld;
  assign sto_lst = sto.lst;
  assign sto.rdy = sto_rdy;

  // internal, software, two external
  assign trg_src = {trg_ext, trg_swo, trg_out};

  la_regs u_regs (
    .bus, .rst, .wen, .ren, .addr, .wdata, .rdata, .ack,
    .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_acq, .cts_trg, .cts_stp,
    .cfg, .ctl_rst, .ctl_acq, .ctl_stp, .trg_swo
  );

  str_dec u_dec (
    .bus, .rst, .ctl_rst, .dec (cfg.dec), .sti (sti), .sto (std)
  );

  // monitor only on the decimated stream
  la_trigger u_trg (
    .bus, .rst, .ctl_rst,
    .cmp_msk (cfg.cmp_msk), .cmp_val (cfg.cmp_val),
    .edg_pos (cfg.edg_pos), .edg_neg (cfg.edg_neg),
    .str (std), .trg_out
  );

  la_acq u_acq (
    .bus, .rst, .cts, .ctl_rst, .ctl_acq, .ctl_stp, .trg_src, .cfg,
    .sti (std), .sto (sto),
    .sts_acq, .sts_trg, .sts_pre, .sts_pst, .cts_acq, .cts_trg, .cts_stp
  );

endmodule

// ==== verification/la_tb.sv ====
// logic analyzer testbench
// random bus and stream stimulus against a transfer level model

`timescale 1ns/1ns

`include "la_regmap.svh"

module la_tb import la_pkg::*; ();

  // accepted input samples per stream test, bound for the capture test
  localparam int n_dec    = 300;
  localparam int n_trg    = 200;
  localparam int n_acq    = 32;
  localparam int n_bp     = 300;
  localparam int plan_xfr = n_dec + n_trg + n_acq + n_bp;
  localparam int per_ns   = 20;

  logic            bus;
  logic            rst;
  logic            wen;
  logic            ren;
  logic [baw-1:0]  addr;
  logic [31:0]     wdata;
  logic [31:0]     rdata;
  logic            ack;
  logic [tw-1:0]   cts;
  logic [1:0]      trg_ext;
  dat_t            sti_dat;
  logic            sti_vld;
  logic            sti_rdy;
  dat_t            sto_dat;
  logic            sto_vld;
  logic            sto_lst;
  logic            sto_rdy;
  logic            trg_out;
  logic            trg_swo;

  // rng states, stimulus and back-pressure
  logic [31:0]     rs;
  logic [31:0]     bs;
  logic            bp;
  int              err_cnt;
  int              trg_cnt;
  int              swo_cnt;
  logic [63:0]     req_cts;
  logic [63:0]     lst_cts;
  dat_t            sent[$];
  dat_t            exp_dat[$];
  dat_t            got_dat[$];
  logic            got_lst[$];
  int              exp_trg[$];
  int              got_trg[$];

  la_top DUT (.*);

  initial bus = 1'b0;
  always #10 bus = ~bus;

  // free running timestamp
  always @(posedge bus) cts <= cts + 64'd1;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_now(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus and stream drivers
  ////////////////////////////////////////////////////////////////////////////

  // one access, ack expected on the next edge only
  task automatic bus_access(input logic wr, input logic [baw-1:0] a, input logic [31:0] d,
                            output logic [31:0] q);
    @(posedge bus);
    #2;
    check("ack", ack, 0);
    wen = wr;
    ren = !wr;
    addr = a;
    wdata = d;
    req_cts = cts;
    @(posedge bus);
    #2;
    wen = 1'b0;
    ren = 1'b0;
    check("ack", ack, 1);
    q = rdata;
  endtask

  task automatic wr(input logic [baw-1:0] a, input logic [31:0] d);
    logic [31:0] q;
    bus_access(1'b1, a, d, q);
  endtask

  task automatic rd(input logic [baw-1:0] a, output logic [31:0] q);
    bus_access(1'b0, a, 32'd0, q);
  endtask

  task automatic rd64(input logic [baw-1:0] a, output logic [63:0] v);
    logic [31:0] lo;
    logic [31:0] hi;
    rd(a, lo);
    rd(a + 7'd4, hi);
    v = {hi, lo};
  endtask

  // n accepted samples with random idle gaps
  task automatic drive_stream(input int n);
    int i;
    i = 0;
    while (i < n) begin
      rs = xorshift(rs);
      sti_vld = (rs[1:0] != 2'd0);
      sti_dat = rs[15:8];
      #16;
      if (sti_vld && sti_rdy) begin
        sent.push_back(sti_dat);
        i++;
      end
      @(posedge bus);
      #2;
    end
    sti_vld = 1'b0;
  endtask

  task automatic wait_out(input int n);
    while (got_dat.size() < n) @(posedge bus);
    @(posedge bus);
    #2;
  endtask

  task automatic clear_queues();
    sent.delete();
    got_dat.delete();
    got_lst.delete();
    got_trg.delete();
    trg_cnt = 0;
  endtask

  // output sink, sampled just before the edge
  always @(posedge bus) begin
    #2;
    if (bp) begin
      bs = xorshift(bs);
      sto_rdy = bs[0] | bs[1];
    end else begin
      sto_rdy = 1'b1;
    end
    #16;
    if (trg_swo) swo_cnt++;
    if (trg_out) begin
      trg_cnt++;
      if (!bp) got_trg.push_back((sto_vld && sto_rdy) ? got_dat.size() : -1);
    end
    if (sto_vld && sto_rdy) begin
      got_dat.push_back(sto_dat);
      got_lst.push_back(sto_lst);
      if (sto_lst) lst_cts = cts;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // model and tests
  ////////////////////////////////////////////////////////////////////////////

  // keep one of dec+1, pattern plus edge against the last kept sample
  task automatic build_model(input int dec, input dat_t msk, input dat_t val,
                             input dat_t pos, input dat_t neg);
    dat_t prv;
    dat_t d;
    int   k;
    logic hit;
    exp_dat.delete();
    exp_trg.delete();
    prv = '0;
    k = 0;
    for (int i = 0; i < sent.size(); i++) begin
      if (i % (dec + 1) == 0) begin
        d = sent[i];
        // any selected bit that went 0 to 1 or 1 to 0
        hit = 1'b0;
        for (int b = 0; b < dw; b++) begin
          if (pos[b] && !prv[b] && d[b]) hit = 1'b1;
          if (neg[b] && prv[b] && !d[b]) hit = 1'b1;
        end
        if (((d ^ val) & msk) == '0 && hit)
          exp_trg.push_back(k);
        exp_dat.push_back(d);
        prv = d;
        k++;
      end
    end
  endtask

  task automatic reg_test();
    logic [baw-1:0] offs [10];
    logic [31:0]    msks [10];
    logic [31:0]    vals [10];
    logic [31:0]    q;
    offs = '{`la_reg_mode, `la_reg_trg, `la_reg_pre, `la_reg_pst, `la_reg_cmp_msk,
             `la_reg_cmp_val, `la_reg_edg_pos, `la_reg_edg_neg, `la_reg_dec, `la_reg_dec};
    msks = '{32'h3, 32'hf, 32'h1ffff, 32'h1ffff, 32'hff,
             32'hff, 32'hff, 32'hff, 32'h1ffff, 32'h1ffff};
    for (int i = 0; i < 10; i++) begin
      rs = xorshift(rs);
      vals[i] = rs;
      wr(offs[i], vals[i]);
    end
    // dec is written twice, the later value stands
    for (int i = 0; i < 10; i++) begin
      if (i != 8) begin
        rd(offs[i], q);
        check("rdata", q, vals[i] & msks[i]);
      end
    end
  endtask

  // continuous capture, all kept samples forwarded
  task automatic stream_test(input logic bpm, input int n);
    int   dec;
    dat_t msk;
    dat_t val;
    dat_t pos;
    dat_t neg;
    rs = xorshift(rs);
    dec = int'(rs[1:0]);
    rs = xorshift(rs);
    {neg, pos, val, msk} = rs;
    wr(`la_reg_ctl, 32'h1);
    wr(`la_reg_mode, 32'h1);
    wr(`la_reg_trg, 32'h0);
    wr(`la_reg_pre, 32'h0);
    wr(`la_reg_dec, 32'(dec));
    wr(`la_reg_cmp_msk, 32'(msk));
    wr(`la_reg_cmp_val, 32'(val));
    wr(`la_reg_edg_pos, 32'(pos));
    wr(`la_reg_edg_neg, 32'(neg));
    clear_queues();
    wr(`la_reg_ctl, 32'h2);
    bp = bpm;
    drive_stream(n);
    build_model(dec, msk, val, pos, neg);
    wait_out(exp_dat.size());
    bp = 1'b0;
    check("sto count", got_dat.size(), exp_dat.size());
    for (int i = 0; i < exp_dat.size(); i++) begin
      check("sto_dat", got_dat[i], exp_dat[i]);
      check("sto_lst", got_lst[i], 0);
    end
    check("trg_out count", trg_cnt, exp_trg.size());
    if (!bpm) begin
      for (int i = 0; i < exp_trg.size(); i++) check("trg_out position", got_trg[i], exp_trg[i]);
    end
  endtask

  // pre, external trigger, post
  task automatic acq_test();
    int          pre;
    int          pst;
    int          k;
    logic [31:0] q;
    logic [63:0] t_acq;
    logic [63:0] t_trg;
    logic [63:0] v;
    bit          in_win;
    rs = xorshift(rs);
    pre = 1 + int'(rs[2:0]);
    pst = 1 + int'(rs[5:3]);
    k = pre + int'(rs[7:6]) % 3;
    wr(`la_reg_ctl, 32'h1);
    wr(`la_reg_mode, 32'h0);
    wr(`la_reg_trg, 32'h4);
    wr(`la_reg_pre, 32'(pre));
    wr(`la_reg_pst, 32'(pst));
    wr(`la_reg_dec, 32'h0);
    clear_queues();
    wr(`la_reg_ctl, 32'h2);
    t_acq = req_cts;
    drive_stream(k);
    wait_out(k);
    rd(`la_reg_sts_pre, q);
    check("sts_pre", q, pre);
    rd(`la_reg_sts_pst, q);
    check("sts_pst", q, 0);
    rd(`la_reg_ctl, q);
    check("status", q, 32'h2);
    // one cycle external trigger
    trg_ext = 2'b01;
    t_trg = cts;
    @(posedge bus);
    #2;
    trg_ext = 2'b00;
    drive_stream(pst + 3);
    wait_out(k + pst);
    repeat (4) @(posedge bus);
    #2;
    check("sto count", got_dat.size(), k + pst);
    for (int i = 0; i < k + pst; i++) begin
      check("sto_dat", got_dat[i], sent[i]);
      check("sto_lst", got_lst[i], (i == k + pst - 1));
    end
    rd(`la_reg_ctl, q);
    check("status", q, 32'hc);
    // counts stay at their limits once the capture ends
    rd(`la_reg_sts_pre, q);
    check("sts_pre", q, pre);
    rd(`la_reg_sts_pst, q);
    check("sts_pst", q, pst);
    rd64(`la_reg_cts_acq_lo, v);
    check("cts_acq", v, t_acq);
    rd64(`la_reg_cts_trg_lo, v);
    check("cts_trg", v, t_trg);
    rd64(`la_reg_cts_stp_lo, v);
    // stop on the last post sample, which leaves one cycle later
    in_win = (v >= t_trg + 64'(pst)) && (v <= lst_cts - 64'd1);
    if (!in_win) fail_now("stop timestamp lies outside the capture window");
  endtask

  task automatic sw_test();
    logic [31:0] q;
    logic [63:0] t_stp;
    logic [63:0] v;
    swo_cnt = 0;
    wr(`la_reg_ctl, 32'h1);
    wr(`la_reg_mode, 32'h0);
    wr(`la_reg_trg, 32'h2);
    wr(`la_reg_pre, 32'h0);
    wr(`la_reg_pst, 32'd100);
    wr(`la_reg_ctl, 32'h2);
    rd(`la_reg_ctl, q);
    check("status", q, 32'h2);
    wr(`la_reg_ctl, 32'h8);
    rd(`la_reg_ctl, q);
    check("status", q, 32'ha);
    // only the trigger write pulses the software trigger
    check("trg_swo pulses", swo_cnt, 1);
    wr(`la_reg_ctl, 32'h4);
    t_stp = req_cts;
    rd(`la_reg_ctl, q);
    check("status", q, 32'hc);
    rd64(`la_reg_cts_stp_lo, v);
    check("cts_stp", v, t_stp);
  endtask

  // watchdog, 40 cycles per planned transfer
  initial begin
    #(plan_xfr * 40 * per_ns);
    fail_now("watchdog expired, the run hung");
  end

  initial begin
    rst = 1'b1;
    wen = 1'b0;
    ren = 1'b0;
    addr = '0;
    wdata = '0;
    cts = '0;
    trg_ext = 2'b00;
    sti_dat = '0;
    sti_vld = 1'b0;
    sto_rdy = 1'b1;
    bp = 1'b0;
    rs = 32'd99;
    bs = 32'd99;
    err_cnt = 0;
    trg_cnt = 0;
    swo_cnt = 0;
    repeat (2) @(posedge bus);
    #2;
    rst = 1'b0;
    reg_test();
    stream_test(1'b0, n_dec);
    stream_test(1'b0, n_trg);
    acq_test();
    sw_test();
    stream_test(1'b1, n_bp);
    if (err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
verilog/la_pkg.sv
verilog/str_if.sv
verilog/la_regs.sv
verilog/str_dec.sv
verilog/la_trigger.sv
verilog/la_acq.sv
verilog/la_top.sv
verification/la_tb.sv

// ==== Makefile ====
# Verilator build and run for the logic analyzer testbench

VERILATOR ?= verilator
TOP       ?= la_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLIST     ?= all.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard verilog/*.sv) $(wildcard verification/*.sv) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
